// File: branch_pkg.sv
`default_nettype none

package branch_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int CB_DEPTH = 4;                      // control buffer slots.
    localparam int CB_IDX   = $clog2(CB_DEPTH);
    localparam int ROB_IDX  = 5;                      // 32-entry ROB.
    localparam int ADDR_W   = 32;
    localparam int CREDIT_W = $clog2(CB_DEPTH + 1);  // must hold CB_DEPTH itself.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // payloads
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [ROB_IDX-1:0] rob_id;
        logic [ADDR_W-1:0]  pc;
    } branch_uop_t;

    // one branch outcome from the execute side.
    typedef struct packed {
        logic               valid;
        logic [ROB_IDX-1:0] rob_id;
        logic               miss_predict;
        logic [ADDR_W-1:0]  target_address;
    } resolve_t;

    // valid means the buffer is not empty, ready means the head is resolved.
    typedef struct packed {
        logic               valid;
        logic               ready;
        logic [ROB_IDX-1:0] rob_id;
        logic               miss_predict;
        logic [ADDR_W-1:0]  target_address;
    } cb_head_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] target_address;
    } redirect_t;

endpackage

`default_nettype wire

// File: branch_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module branch_dispatch
    import branch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        in_valid,
    input  branch_uop_t in_uop,
    output logic        in_ready,

    output logic        cb_push,
    output branch_uop_t cb_uop,
    input  logic        credit_return,

    input  logic        flush
);

    logic                stg_valid;
    branch_uop_t         stg_uop;
    logic [CREDIT_W-1:0] credits;
    logic [CREDIT_W-1:0] credits_next;
    logic                accept;
    logic                has_credit;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign has_credit = (credits != '0);

    // the stage can take a new uop if it is empty or is about to drain.
    assign in_ready = !stg_valid || has_credit;
    assign accept   = in_valid && in_ready;

    assign cb_push = stg_valid && has_credit && !flush;  // a flushed uop is never sent.
    assign cb_uop  = stg_uop;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // staging register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            stg_valid <= 1'b0;
        end else if (flush) begin
            stg_valid <= 1'b0;      // younger than the mispredicted branch.
        end else if (accept) begin
            stg_valid <= 1'b1;
        end else if (cb_push) begin
            stg_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stg_uop <= in_uop;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // credits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        credits_next = credits;
        if (cb_push && !credit_return) begin
            credits_next = credits - CREDIT_W'(1);
        end else if (!cb_push && credit_return) begin
            credits_next = credits + CREDIT_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            credits <= CREDIT_W'(CB_DEPTH);  // the buffer is empty after either one.
        end else begin
            credits <= credits_next;
        end
    end

    // an underflow wraps to a value above CB_DEPTH, so one bound catches
    // both a spurious credit_return and a push without a credit.
    a_credit_range: assert property (
        @(posedge clk) disable iff (rst) credits <= CREDIT_W'(CB_DEPTH)
    );

endmodule

`default_nettype wire

// File: control_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module control_buffer
    import branch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        cb_push,
    input  branch_uop_t cb_uop,
    output logic        credit_return,

    input  resolve_t    resolve,

    output cb_head_t    head,
    input  logic        pop,

    input  logic        flush
);

    typedef struct packed {
        logic [ROB_IDX-1:0] rob_id;
        logic               ready;
        logic               miss_predict;
        logic [ADDR_W-1:0]  target_address;
    } cb_entry_t;

    cb_entry_t entries [CB_DEPTH];

    // the extra top bit is the wrap flag.
    logic [CB_IDX:0]   wr_ptr;
    logic [CB_IDX:0]   rd_ptr;
    logic [CB_IDX-1:0] wr_idx;
    logic [CB_IDX-1:0] rd_idx;
    logic              wr_flag;
    logic              rd_flag;
    logic [CB_IDX:0]   count;
    logic              empty;
    logic              full;
    logic [CB_DEPTH-1:0] live;

    assign {wr_flag, wr_idx} = wr_ptr;
    assign {rd_flag, rd_idx} = rd_ptr;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_idx == rd_idx) && (wr_flag != rd_flag);
    assign count = wr_ptr - rd_ptr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // occupancy per slot
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a slot is live when its distance from the read index is below count.
    always_comb begin
        logic [CB_IDX-1:0] offset;
        for (int i = 0; i < CB_DEPTH; i++) begin
            offset  = CB_IDX'(i) - rd_idx;
            live[i] = ({1'b0, offset} < count);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // entry storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (resolve.valid) begin
            for (int i = 0; i < CB_DEPTH; i++) begin
                if (live[i] && (entries[i].rob_id == resolve.rob_id)) begin
                    entries[i].ready          <= 1'b1;
                    entries[i].miss_predict   <= resolve.miss_predict;
                    entries[i].target_address <= resolve.target_address;
                end
            end
        end

        if (cb_push) begin
            entries[wr_idx].rob_id <= cb_uop.rob_id;
            entries[wr_idx].ready  <= 1'b0;   // waits for its resolution.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;             // every tracked branch is younger.
            rd_ptr <= '0;
        end else begin
            if (cb_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // a flush hands back all credits at once in dispatch.
    assign credit_return = pop && !flush;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // head view
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign head.valid          = !empty;
    assign head.ready          = entries[rd_idx].ready;
    assign head.rob_id         = entries[rd_idx].rob_id;
    assign head.miss_predict   = entries[rd_idx].miss_predict;
    assign head.target_address = entries[rd_idx].target_address;

    // dispatch must hold a credit for every push.
    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst) cb_push |-> !full
    );

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst) pop |-> !empty
    );

endmodule

`default_nettype wire

// File: branch_commit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_commit
    import branch_pkg::*;
(
    input  logic               clk,
    input  logic               rst,

    input  cb_head_t           head,
    input  logic [ROB_IDX-1:0] rob_head_id,

    output logic               pop,
    output logic               retire,
    output redirect_t          redirect,
    output logic               flush
);

    logic              retire_q;
    logic              flush_q;
    logic [ADDR_W-1:0] redir_target_q;
    logic              at_rob_head;
    logic              mispredict_pop;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // retirement decision
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign at_rob_head = (head.rob_id == rob_head_id);

    // the head still shows a younger branch during the flush cycle.
    assign pop = head.valid && head.ready && at_rob_head && !flush_q;

    assign mispredict_pop = pop && head.miss_predict;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // registered outcome
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_q <= 1'b0;
            flush_q  <= 1'b0;
        end else begin
            retire_q <= pop;
            flush_q  <= mispredict_pop;   // front end and buffer recover together.
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            redir_target_q <= head.target_address;
        end
    end

    assign retire                  = retire_q;
    assign redirect.valid          = flush_q;
    assign redirect.target_address = redir_target_q;
    assign flush                   = flush_q;

    // the buffer must drop every entry on the edge that ends a flush.
    a_flush_empties: assert property (
        @(posedge clk) disable iff (rst) flush |=> !head.valid
    );

endmodule

`default_nettype wire

// File: branch_tracker_top.sv
`timescale 1ns/1ps
`default_nettype none

module branch_tracker_top
    import branch_pkg::*;
(
    input  logic               clk,
    input  logic               rst,

    input  logic               in_valid,
    input  branch_uop_t        in_uop,
    output logic               in_ready,

    input  resolve_t           resolve,
    input  logic [ROB_IDX-1:0] rob_head_id,

    output logic               retire,
    output redirect_t          redirect
);

    logic        cb_push;
    branch_uop_t cb_uop;
    logic        credit_return;
    cb_head_t    head;
    logic        pop;
    logic        flush;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // dispatch, buffer, commit
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    branch_dispatch i_dispatch (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_uop        (in_uop),
        .in_ready      (in_ready),
        .cb_push       (cb_push),
        .cb_uop        (cb_uop),
        .credit_return (credit_return),
        .flush         (flush)
    );

    control_buffer i_buffer (
        .clk           (clk),
        .rst           (rst),
        .cb_push       (cb_push),
        .cb_uop        (cb_uop),
        .credit_return (credit_return),
        .resolve       (resolve),
        .head          (head),
        .pop           (pop),
        .flush         (flush)
    );

    branch_commit i_commit (
        .clk         (clk),
        .rst         (rst),
        .head        (head),
        .rob_head_id (rob_head_id),
        .pop         (pop),
        .retire      (retire),
        .redirect    (redirect),
        .flush       (flush)
    );

endmodule

`default_nettype wire

// File: tb_branch_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_branch_tracker
    import branch_pkg::*;
();

    logic               clk;
    logic               rst;
    logic               in_valid;
    branch_uop_t        in_uop;
    logic               in_ready;
    resolve_t           resolve;
    logic [ROB_IDX-1:0] rob_head_id;
    logic               retire;
    redirect_t          redirect;

    int    fd;
    string line;
    int    n_fields;
    int    line_no;
    int    vector_count;
    int    cycle_count = 0;
    int    cycle_limit = 0;

    // one vector line, inputs first and then the expected outputs.
    logic [31:0] v_in_valid;
    logic [31:0] v_in_rob_id;
    logic [31:0] v_in_pc;
    logic [31:0] v_res_valid;
    logic [31:0] v_res_rob_id;
    logic [31:0] v_res_miss;
    logic [31:0] v_res_target;
    logic [31:0] v_rob_head;
    logic [31:0] x_in_ready;
    logic [31:0] x_retire;
    logic [31:0] x_redir_valid;
    logic [31:0] x_redir_target;

    branch_tracker_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_uop      (in_uop),
        .in_ready    (in_ready),
        .resolve     (resolve),
        .rob_head_id (rob_head_id),
        .retire      (retire),
        .redirect    (redirect)
    );

    always #20 clk = ~clk;     // 40 ns period.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reporting
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERROR line %0d: %s expected 0x%0h got 0x%0h", line_no, name, expected, actual);
        $display("Test failures found");
        $fatal(1, "output mismatch");
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "run aborted");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // vector file
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic bit is_data_line(input string s);
        if (s.len() == 0) begin
            return 1'b0;
        end
        if (s[0] == "#" || s[0] == "\n" || s[0] == "\r") begin
            return 1'b0;
        end
        return 1'b1;
    endfunction

    // a first pass over the file sizes the timeout.
    task automatic count_vectors();
        int    cfd;
        string s;
        vector_count = 0;
        cfd = $fopen("branch_vectors.txt", "r");
        if (cfd == 0) begin
            report_problem("could not open branch_vectors.txt for reading");
        end
        while ($fgets(s, cfd) != 0) begin
            if (is_data_line(s)) begin
                vector_count++;
            end
        end
        $fclose(cfd);
    endtask

    task automatic apply_vector();
        in_valid               = v_in_valid[0];
        in_uop.rob_id          = v_in_rob_id[ROB_IDX-1:0];
        in_uop.pc              = v_in_pc[ADDR_W-1:0];
        resolve.valid          = v_res_valid[0];
        resolve.rob_id         = v_res_rob_id[ROB_IDX-1:0];
        resolve.miss_predict   = v_res_miss[0];
        resolve.target_address = v_res_target[ADDR_W-1:0];
        rob_head_id            = v_rob_head[ROB_IDX-1:0];
    endtask

    task automatic check_outputs();
        assert (in_ready === x_in_ready[0])
            else report_mismatch("in_ready", x_in_ready, {31'b0, in_ready});
        assert (retire === x_retire[0])
            else report_mismatch("retire", x_retire, {31'b0, retire});
        assert (redirect.valid === x_redir_valid[0])
            else report_mismatch("redirect.valid", x_redir_valid, {31'b0, redirect.valid});
        // the target only means something while the redirect is valid.
        if (x_redir_valid[0]) begin
            assert (redirect.target_address === x_redir_target[ADDR_W-1:0])
                else report_mismatch("redirect.target_address", x_redir_target,
                                     redirect.target_address);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_uop      = '0;
        resolve     = '0;
        rob_head_id = '1;
        line_no     = 0;

        count_vectors();
        cycle_limit = vector_count + 20;

        fd = $fopen("branch_vectors.txt", "r");
        if (fd == 0) begin
            report_problem("could not open branch_vectors.txt for reading");
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (is_data_line(line)) begin
                n_fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                                   v_in_valid, v_in_rob_id, v_in_pc, v_res_valid,
                                   v_res_rob_id, v_res_miss, v_res_target, v_rob_head,
                                   x_in_ready, x_retire, x_redir_valid, x_redir_target);
                if (n_fields != 12) begin
                    report_problem($sformatf("line %0d of the vector file is malformed",
                                             line_no));
                end
                apply_vector();
                #19;                      // just before the next rising edge.
                check_outputs();
                @(negedge clk);
            end
        end
        $fclose(fd);

        $display("All tests passed!");
        $finish;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            report_problem($sformatf("timeout after %0d cycles, the vectors never finished",
                                     cycle_limit));
        end
    end

endmodule

`default_nettype wire

// File: branch_vectors.txt
# in_valid in_rob_id in_pc res_valid res_rob_id res_miss res_target rob_head_id
# then expected: in_ready retire redirect_valid redirect_target, all hex
# idle after reset
0 00 00000000 0 00 0 00000000 1f 1 0 0 00000000
# four pushes use every credit, the fifth uop stays staged
1 01 00000100 0 00 0 00000000 1f 1 0 0 00000000
1 02 00000104 0 00 0 00000000 1f 1 0 0 00000000
1 03 00000108 0 00 0 00000000 1f 1 0 0 00000000
1 04 0000010c 0 00 0 00000000 1f 1 0 0 00000000
1 05 00000110 0 00 0 00000000 1f 1 0 0 00000000
# out of order resolution, retirement in program order
1 06 00000114 1 03 0 00000200 1f 0 0 0 00000000
1 06 00000114 1 02 0 00000204 1f 0 0 0 00000000
1 06 00000114 0 00 0 00000000 01 0 0 0 00000000
1 06 00000114 1 01 0 00000208 01 0 0 0 00000000
1 06 00000114 0 00 0 00000000 01 0 0 0 00000000
1 06 00000114 0 00 0 00000000 02 1 1 0 00000000
0 00 00000000 0 00 0 00000000 03 1 1 0 00000000
0 00 00000000 1 05 0 00000300 04 1 1 0 00000000
# 04 mispredicts, 05 06 07 and the staged 08 are dropped
1 07 00000118 1 04 1 00000400 04 1 0 0 00000000
1 08 0000011c 0 00 0 00000000 04 1 0 0 00000000
0 00 00000000 0 00 0 00000000 05 1 1 1 00000400
0 00 00000000 0 00 0 00000000 05 1 0 0 00000000
# dispatch resumes after the flush
1 0a 00000480 0 00 0 00000000 06 1 0 0 00000000
1 0b 00000484 0 00 0 00000000 1f 1 0 0 00000000
0 00 00000000 1 0a 0 00000500 1f 1 0 0 00000000
0 00 00000000 1 0b 0 00000504 0a 1 0 0 00000000
0 00 00000000 0 00 0 00000000 0b 1 1 0 00000000
0 00 00000000 0 00 0 00000000 1f 1 1 0 00000000
# second mispredict flushes the unresolved 0d
1 0c 00000488 0 00 0 00000000 1f 1 0 0 00000000
1 0d 0000048c 0 00 0 00000000 1f 1 0 0 00000000
0 00 00000000 1 0c 1 00000600 1f 1 0 0 00000000
0 00 00000000 0 00 0 00000000 0c 1 0 0 00000000
0 00 00000000 1 0d 0 00000700 0d 1 1 1 00000600
0 00 00000000 0 00 0 00000000 0d 1 0 0 00000000
0 00 00000000 0 00 0 00000000 1f 1 0 0 00000000
# credits are full again after the flush
1 10 00000440 0 00 0 00000000 1f 1 0 0 00000000
1 11 00000444 0 00 0 00000000 1f 1 0 0 00000000
1 12 00000448 0 00 0 00000000 1f 1 0 0 00000000
1 13 0000044c 0 00 0 00000000 1f 1 0 0 00000000
1 14 00000450 0 00 0 00000000 1f 1 0 0 00000000
0 00 00000000 0 00 0 00000000 1f 0 0 0 00000000
0 00 00000000 1 10 0 00000800 1f 0 0 0 00000000
0 00 00000000 0 00 0 00000000 10 0 0 0 00000000
0 00 00000000 0 00 0 00000000 1f 1 1 0 00000000
0 00 00000000 0 00 0 00000000 1f 1 0 0 00000000

// File: compile.f
branch_pkg.sv
branch_dispatch.sv
control_buffer.sv
branch_commit.sv
branch_tracker_top.sv
tb_branch_tracker.sv
